//--- hdl/chdr_ep_defines.svh
// CHDR ingress endpoint widths, header field positions, packet-type codes and register map
`ifndef CHDR_EP_DEFINES_SVH
`define CHDR_EP_DEFINES_SVH

// --------------------------------------------------------------------
// Widths
// --------------------------------------------------------------------
`define CHDR_W          64
`define EPID_W          16
`define VC_W            6
`define CNT_W           32
`define APB_AW          8
`define PKT_TYPE_W      3
`define NUM_DATA_O_DEF  2

// Field positions in the first beat of a packet
`define HDR_VC_HI       63
`define HDR_VC_LO       58
`define HDR_TYPE_HI     55
`define HDR_TYPE_LO     53
`define HDR_DST_EPID_HI 15
`define HDR_DST_EPID_LO 0

// Packet types (3 and 5 are reserved)
`define PKT_TYPE_MGMT    3'd0
`define PKT_TYPE_STRS    3'd1
`define PKT_TYPE_STRC    3'd2
`define PKT_TYPE_CTRL    3'd4
`define PKT_TYPE_DATA    3'd6
`define PKT_TYPE_DATA_TS 3'd7

// --------------------------------------------------------------------
// Register offsets
// --------------------------------------------------------------------
`define REG_EPID_SELF       8'h00
`define REG_RESET_AND_FLUSH 8'h04
`define REG_DATA_PKT_CNT    8'h08
`define REG_OTHER_PKT_CNT   8'h0C
`define REG_ROUTE_ERR_CNT   8'h10

`endif

//--- hdl/chdr_ep_pkg.sv
// Common types shared by the CHDR ingress data path and its register file
`include "chdr_ep_defines.svh"

package chdr_ep_pkg;

  // --------------------------------------------------------------------
  // Bus and field types
  // --------------------------------------------------------------------

  // One beat of the CHDR stream
  typedef logic [`CHDR_W-1:0] chdr_word_t;

  // Endpoint ID, as programmed and as carried in the header
  typedef logic [`EPID_W-1:0] epid_t;

  // Virtual channel field of the header
  typedef logic [`VC_W-1:0]   vc_t;

  // Packet counter value
  typedef logic [`CNT_W-1:0]  pkt_cnt_t;

  // APB byte address
  typedef logic [`APB_AW-1:0] apb_addr_t;

  // --------------------------------------------------------------------
  // Classifier verdict on a header
  // --------------------------------------------------------------------
  typedef enum logic [1:0] {
    PKT_DATA,       // data-class packet for this endpoint, forwarded
    PKT_OTHER,      // control, status, management or reserved, dropped
    PKT_MISROUTED   // data-class packet for another endpoint, dropped
  } pkt_class_e;

endpackage

//--- hdl/chdr_pkt_classifier.sv
// CHDR header classifier stage that forwards local data-class packets and flags packet counts
`include "chdr_ep_defines.svh"

module chdr_pkt_classifier
  import chdr_ep_pkg::*;
(
  input  logic       rfnoc_chdr_clk,
  input  logic       rfnoc_chdr_rst,
  // Control from the register file
  input  logic       i_flush,
  input  epid_t      i_epid_self,
  // CHDR stream in
  input  chdr_word_t i_tdata,
  input  logic       i_tlast,
  input  logic       i_tvalid,
  output logic       o_tready,
  // Kept packets towards the router
  output chdr_word_t o_out_tdata,
  output logic       o_out_tlast,
  output logic       o_out_tvalid,
  input  logic       i_out_tready,
  // One pulse per accepted header
  output logic       o_data_stb,
  output logic       o_other_stb,
  output logic       o_misrouted_stb
);

  logic                   hdr_q;
  logic                   keep_q;
  logic                   out_valid_q;
  logic                   out_last_q;
  chdr_word_t             out_data_q;
  logic [`PKT_TYPE_W-1:0] pkt_type;
  epid_t                  dst_epid;
  pkt_class_e             hdr_class;
  logic                   cur_keep;
  logic                   out_free;
  logic                   beat_acc;
  logic                   hdr_acc;

  // --------------------------------------------------------------------
  // Header decode
  // --------------------------------------------------------------------
  assign pkt_type = i_tdata[`HDR_TYPE_HI:`HDR_TYPE_LO];
  assign dst_epid = i_tdata[`HDR_DST_EPID_HI:`HDR_DST_EPID_LO];

  always_comb begin
    case (pkt_type)
      `PKT_TYPE_DATA, `PKT_TYPE_DATA_TS, `PKT_TYPE_STRC:
        hdr_class = (dst_epid == i_epid_self) ? PKT_DATA : PKT_MISROUTED;
      // Management, stream status, control and reserved codes
      default:
        hdr_class = PKT_OTHER;
    endcase
  end

  // Body beats follow the verdict taken on their header
  assign cur_keep = hdr_q ? (hdr_class == PKT_DATA) : keep_q;
  assign out_free = !out_valid_q || i_out_tready;

  // Dropped beats are always taken while kept beats wait for room downstream
  assign o_tready = !i_flush && (cur_keep ? out_free : 1'b1);
  assign beat_acc = i_tvalid && o_tready;
  assign hdr_acc  = beat_acc && hdr_q;

  assign o_data_stb      = hdr_acc && (hdr_class == PKT_DATA);
  assign o_other_stb     = hdr_acc && (hdr_class == PKT_OTHER);
  assign o_misrouted_stb = hdr_acc && (hdr_class == PKT_MISROUTED);

  // --------------------------------------------------------------------
  // Packet tracking and output register
  // --------------------------------------------------------------------
  always_ff @(posedge rfnoc_chdr_clk) begin
    if (rfnoc_chdr_rst || i_flush) begin
      hdr_q       <= 1'b1;
      keep_q      <= 1'b0;
      out_valid_q <= 1'b0;
    end else begin
      if (beat_acc) begin
        hdr_q <= i_tlast;
      end
      if (hdr_acc) begin
        keep_q <= (hdr_class == PKT_DATA);
      end
      if (beat_acc && cur_keep) begin
        out_valid_q <= 1'b1;
      end else if (i_out_tready) begin
        out_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge rfnoc_chdr_clk) begin
    if (beat_acc && cur_keep) begin
      out_data_q <= i_tdata;
      out_last_q <= i_tlast;
    end
  end

  assign o_out_tdata  = out_data_q;
  assign o_out_tlast  = out_last_q;
  assign o_out_tvalid = out_valid_q;

endmodule

//--- hdl/chdr_vc_router.sv
// CHDR router stage that steers whole packets to an output port chosen by the header VC
`include "chdr_ep_defines.svh"

module chdr_vc_router
  import chdr_ep_pkg::*;
#(
  parameter int NUM_DATA_O = `NUM_DATA_O_DEF
) (
  input  logic                              rfnoc_chdr_clk,
  input  logic                              rfnoc_chdr_rst,
  input  logic                              i_flush,
  // Stream from the classifier
  input  chdr_word_t                        i_tdata,
  input  logic                              i_tlast,
  input  logic                              i_tvalid,
  output logic                              o_tready,
  // Output ports
  output chdr_word_t [NUM_DATA_O-1:0]       o_m_tdata,
  output logic       [NUM_DATA_O-1:0]       o_m_tlast,
  output logic       [NUM_DATA_O-1:0]       o_m_tvalid,
  input  logic       [NUM_DATA_O-1:0]       i_m_tready
);

  localparam int PORT_W = (NUM_DATA_O > 1) ? $clog2(NUM_DATA_O) : 1;

  logic              hdr_q;
  logic [PORT_W-1:0] dest_q;
  logic              hold_valid_q;
  logic              hold_last_q;
  chdr_word_t        hold_data_q;
  vc_t               hdr_vc;
  logic [PORT_W-1:0] hdr_port;
  logic [PORT_W-1:0] cur_port;
  logic              beat_acc;

  // --------------------------------------------------------------------
  // Port selection
  // --------------------------------------------------------------------
  assign hdr_vc   = i_tdata[`HDR_VC_HI:`HDR_VC_LO];
  // Out of range VC falls back to port 0
  assign hdr_port = (hdr_vc < NUM_DATA_O) ? hdr_vc[PORT_W-1:0] : '0;

  // dest_q still holds the port of the packet in flight
  assign cur_port = hdr_q ? hdr_port : dest_q;

  // Single hold register, freed only by the port it is presented on
  assign o_tready = !i_flush && (!hold_valid_q || i_m_tready[dest_q]);
  assign beat_acc = i_tvalid && o_tready;

  always_ff @(posedge rfnoc_chdr_clk) begin
    if (rfnoc_chdr_rst || i_flush) begin
      hdr_q        <= 1'b1;
      dest_q       <= '0;
      hold_valid_q <= 1'b0;
    end else begin
      if (beat_acc) begin
        hdr_q        <= i_tlast;
        dest_q       <= cur_port;
        hold_valid_q <= 1'b1;
      end else if (i_m_tready[dest_q]) begin
        hold_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge rfnoc_chdr_clk) begin
    if (beat_acc) begin
      hold_data_q <= i_tdata;
      hold_last_q <= i_tlast;
    end
  end

  // --------------------------------------------------------------------
  // Output fan-out
  // --------------------------------------------------------------------
  for (genvar g = 0; g < NUM_DATA_O; g++) begin : g_port
    assign o_m_tdata[g]  = hold_data_q;
    assign o_m_tlast[g]  = hold_last_q;
    assign o_m_tvalid[g] = hold_valid_q && (dest_q == PORT_W'(g));
  end

endmodule

//--- hdl/chdr_ep_regs.sv
// APB register file for the endpoint ID, the data path flush and the packet counters
`include "chdr_ep_defines.svh"

module chdr_ep_regs
  import chdr_ep_pkg::*;
(
  input  logic        rfnoc_chdr_clk,
  input  logic        rfnoc_chdr_rst,
  // APB slave
  input  logic        i_psel,
  input  logic        i_penable,
  input  logic        i_pwrite,
  input  apb_addr_t   i_paddr,
  input  logic [31:0] i_pwdata,
  output logic        o_pready,
  output logic [31:0] o_prdata,
  output logic        o_pslverr,
  // Count strobes from the classifier
  input  logic        i_data_stb,
  input  logic        i_other_stb,
  input  logic        i_misrouted_stb,
  // Data path control
  output epid_t       o_epid_self,
  output logic        o_flush
);

  logic        pready_q;
  logic        pslverr_q;
  logic [31:0] prdata_q;
  epid_t       epid_q;
  logic        flush_q;
  pkt_cnt_t    cnt_q [3];
  logic [2:0]  cnt_stb;
  logic        access;
  logic        dec_err;
  logic [31:0] dec_rdata;

  // Access is taken in the first access-phase cycle and answered one cycle later
  assign access = i_psel && i_penable && !pready_q;

  // --------------------------------------------------------------------
  // Address decode
  // --------------------------------------------------------------------
  always_comb begin
    dec_rdata = '0;
    dec_err   = 1'b0;
    case (i_paddr)
      `REG_EPID_SELF:       dec_rdata = {{(32-`EPID_W){1'b0}}, epid_q};
      `REG_RESET_AND_FLUSH: dec_err   = !i_pwrite;
      `REG_DATA_PKT_CNT:    begin dec_rdata = cnt_q[0]; dec_err = i_pwrite; end
      `REG_OTHER_PKT_CNT:   begin dec_rdata = cnt_q[1]; dec_err = i_pwrite; end
      `REG_ROUTE_ERR_CNT:   begin dec_rdata = cnt_q[2]; dec_err = i_pwrite; end
      default:              dec_err   = 1'b1;
    endcase
  end

  always_ff @(posedge rfnoc_chdr_clk) begin
    if (rfnoc_chdr_rst) begin
      pready_q  <= 1'b0;
      pslverr_q <= 1'b0;
      epid_q    <= '0;
      flush_q   <= 1'b0;
    end else begin
      pready_q  <= access;
      pslverr_q <= access && dec_err;
      flush_q   <= 1'b0;
      if (access && i_pwrite && !dec_err) begin
        if (i_paddr == `REG_EPID_SELF) begin
          epid_q <= i_pwdata[`EPID_W-1:0];
        end else begin
          flush_q <= i_pwdata[0];
        end
      end
    end
  end

  // Read data is captured in the first access cycle
  always_ff @(posedge rfnoc_chdr_clk) begin
    if (access) begin
      prdata_q <= dec_rdata;
    end
  end

  // --------------------------------------------------------------------
  // Packet counters that wrap at their width
  // --------------------------------------------------------------------
  assign cnt_stb = {i_misrouted_stb, i_other_stb, i_data_stb};

  always_ff @(posedge rfnoc_chdr_clk) begin
    for (int i = 0; i < 3; i++) begin
      if (rfnoc_chdr_rst || flush_q) begin
        cnt_q[i] <= '0;
      end else if (cnt_stb[i]) begin
        cnt_q[i] <= cnt_q[i] + 1'b1;
      end
    end
  end

  assign o_pready    = pready_q;
  assign o_pslverr   = pslverr_q;
  assign o_prdata    = prdata_q;
  assign o_epid_self = epid_q;
  assign o_flush     = flush_q;

endmodule

//--- hdl/chdr_ingress_endpoint.sv
// CHDR ingress endpoint top with classifier, VC router and APB register file
`include "chdr_ep_defines.svh"

module chdr_ingress_endpoint
  import chdr_ep_pkg::*;
#(
  parameter int NUM_DATA_O = `NUM_DATA_O_DEF
) (
  input  logic                        rfnoc_chdr_clk,
  input  logic                        rfnoc_chdr_rst,
  // CHDR stream in
  input  chdr_word_t                  i_chdr_tdata,
  input  logic                        i_chdr_tlast,
  input  logic                        i_chdr_tvalid,
  output logic                        o_chdr_tready,
  // Data ports out
  output chdr_word_t [NUM_DATA_O-1:0] o_data_tdata,
  output logic       [NUM_DATA_O-1:0] o_data_tlast,
  output logic       [NUM_DATA_O-1:0] o_data_tvalid,
  input  logic       [NUM_DATA_O-1:0] i_data_tready,
  // APB slave
  input  logic                        i_psel,
  input  logic                        i_penable,
  input  logic                        i_pwrite,
  input  apb_addr_t                   i_paddr,
  input  logic [31:0]                 i_pwdata,
  output logic                        o_pready,
  output logic [31:0]                 o_prdata,
  output logic                        o_pslverr
);

  chdr_word_t cls_tdata;
  logic       cls_tlast;
  logic       cls_tvalid;
  logic       cls_tready;
  logic       data_stb;
  logic       other_stb;
  logic       misrouted_stb;
  epid_t      epid_self;
  logic       flush;

  // --------------------------------------------------------------------
  // Pipeline, classifier then router
  // --------------------------------------------------------------------
  chdr_pkt_classifier u_classifier (
    .rfnoc_chdr_clk (rfnoc_chdr_clk),
    .rfnoc_chdr_rst (rfnoc_chdr_rst),
    .i_flush        (flush),
    .i_epid_self    (epid_self),
    .i_tdata        (i_chdr_tdata),
    .i_tlast        (i_chdr_tlast),
    .i_tvalid       (i_chdr_tvalid),
    .o_tready       (o_chdr_tready),
    .o_out_tdata    (cls_tdata),
    .o_out_tlast    (cls_tlast),
    .o_out_tvalid   (cls_tvalid),
    .i_out_tready   (cls_tready),
    .o_data_stb     (data_stb),
    .o_other_stb    (other_stb),
    .o_misrouted_stb(misrouted_stb)
  );

  chdr_vc_router #(
    .NUM_DATA_O(NUM_DATA_O)
  ) u_router (
    .rfnoc_chdr_clk(rfnoc_chdr_clk),
    .rfnoc_chdr_rst(rfnoc_chdr_rst),
    .i_flush       (flush),
    .i_tdata       (cls_tdata),
    .i_tlast       (cls_tlast),
    .i_tvalid      (cls_tvalid),
    .o_tready      (cls_tready),
    .o_m_tdata     (o_data_tdata),
    .o_m_tlast     (o_data_tlast),
    .o_m_tvalid    (o_data_tvalid),
    .i_m_tready    (i_data_tready)
  );

  // Register file beside the pipeline
  chdr_ep_regs u_regs (
    .rfnoc_chdr_clk (rfnoc_chdr_clk),
    .rfnoc_chdr_rst (rfnoc_chdr_rst),
    .i_psel         (i_psel),
    .i_penable      (i_penable),
    .i_pwrite       (i_pwrite),
    .i_paddr        (i_paddr),
    .i_pwdata       (i_pwdata),
    .o_pready       (o_pready),
    .o_prdata       (o_prdata),
    .o_pslverr      (o_pslverr),
    .i_data_stb     (data_stb),
    .i_other_stb    (other_stb),
    .i_misrouted_stb(misrouted_stb),
    .o_epid_self    (epid_self),
    .o_flush        (flush)
  );

endmodule

//--- tb/chdr_ep_checker.sv
// Scoreboard for the CHDR ingress endpoint that compares output port beats with expected queues
module chdr_ep_checker (
  input logic             rfnoc_chdr_clk,
  input logic             rfnoc_chdr_rst,
  input logic [1:0][63:0] i_tdata,
  input logic [1:0]       i_tlast,
  input logic [1:0]       i_tvalid,
  input logic [1:0]       i_tready
);

  // Expected beats per port packed as {last, data}
  logic [64:0] exp_q0 [$];
  logic [64:0] exp_q1 [$];
  int          errors   = 0;
  int          checks   = 0;
  int          compared = 0;

  task automatic expect_beat(input int port, input logic last, input logic [63:0] data);
    if (port == 0) begin
      exp_q0.push_back({last, data});
    end else begin
      exp_q1.push_back({last, data});
    end
  endtask

  function automatic int pending_beats();
    return exp_q0.size() + exp_q1.size();
  endfunction

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] expected);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("FAILED %0t: %s is %h, expected %h", $time, what, got, expected);
    end
  endtask

  task automatic compare_beat(input int port, input logic [64:0] got);
    logic [64:0] exp_beat;
    checks++;
    if ((port == 0 && exp_q0.size() == 0) || (port == 1 && exp_q1.size() == 0)) begin
      errors++;
      $display("Unexpected beat on port %0d at time %0t with data %h, no beat was due there",
               port, $time, got[63:0]);
    end else begin
      exp_beat = (port == 0) ? exp_q0.pop_front() : exp_q1.pop_front();
      compared++;
      if (got !== exp_beat) begin
        errors++;
        $display("FAILED %0t: port %0d got last=%b data=%h, expected last=%b data=%h",
                 $time, port, got[64], got[63:0], exp_beat[64], exp_beat[63:0]);
      end
    end
  endtask

  // Sampled on the rising edge before the DUT registers update
  always @(posedge rfnoc_chdr_clk) begin
    if (!rfnoc_chdr_rst) begin
      for (int p = 0; p < 2; p++) begin
        if (i_tvalid[p] && i_tready[p]) begin
          compare_beat(p, {i_tlast[p], i_tdata[p]});
        end
      end
    end
  end

endmodule

//--- tb/tb_chdr_ingress_endpoint.sv
// Testbench for the CHDR ingress endpoint with APB access, random packets and back-pressure
module tb_chdr_ingress_endpoint;

  localparam int NUM_PORTS = 2;

  // Packet types and register offsets of the endpoint
  localparam logic [2:0] TYPE_STRC       = 3'd2;
  localparam logic [2:0] TYPE_DATA       = 3'd6;
  localparam logic [2:0] TYPE_DATA_TS    = 3'd7;
  localparam logic [7:0] ADDR_EPID       = 8'h00;
  localparam logic [7:0] ADDR_FLUSH      = 8'h04;
  localparam logic [7:0] ADDR_DATA_CNT   = 8'h08;
  localparam logic [7:0] ADDR_OTHER_CNT  = 8'h0C;
  localparam logic [7:0] ADDR_ROUTE_ERR  = 8'h10;
  localparam logic [7:0] ADDR_UNMAPPED   = 8'h20;
  localparam int         ROUTE_OTHER     = -1;
  localparam int         ROUTE_MISROUTED = -2;

  logic                  rfnoc_chdr_clk;
  logic                  rfnoc_chdr_rst;
  logic [63:0]           chdr_tdata;
  logic                  chdr_tlast;
  logic                  chdr_tvalid;
  logic                  chdr_tready;
  logic [1:0][63:0]      data_tdata;
  logic [1:0]            data_tlast;
  logic [1:0]            data_tvalid;
  logic [1:0]            data_tready;
  logic                  psel;
  logic                  penable;
  logic                  pwrite;
  logic [7:0]            paddr;
  logic [31:0]           pwdata;
  logic                  pready;
  logic [31:0]           prdata;
  logic                  pslverr;

  integer                seed       = 2;
  logic [31:0]           rdy_rnd;
  logic                  bp_en      = 1'b0;
  logic [15:0]           epid       = 16'h0000;
  int                    exp_data   = 0;
  int                    exp_other  = 0;
  int                    exp_misrt  = 0;
  int                    beats_sent = 0;
  int                    cycle_cnt  = 0;
  int                    errs_start;

  chdr_ingress_endpoint #(
    .NUM_DATA_O(NUM_PORTS)
  ) uut (
    .rfnoc_chdr_clk(rfnoc_chdr_clk),
    .rfnoc_chdr_rst(rfnoc_chdr_rst),
    .i_chdr_tdata  (chdr_tdata),
    .i_chdr_tlast  (chdr_tlast),
    .i_chdr_tvalid (chdr_tvalid),
    .o_chdr_tready (chdr_tready),
    .o_data_tdata  (data_tdata),
    .o_data_tlast  (data_tlast),
    .o_data_tvalid (data_tvalid),
    .i_data_tready (data_tready),
    .i_psel        (psel),
    .i_penable     (penable),
    .i_pwrite      (pwrite),
    .i_paddr       (paddr),
    .i_pwdata      (pwdata),
    .o_pready      (pready),
    .o_prdata      (prdata),
    .o_pslverr     (pslverr)
  );

  chdr_ep_checker u_chk (
    .rfnoc_chdr_clk(rfnoc_chdr_clk),
    .rfnoc_chdr_rst(rfnoc_chdr_rst),
    .i_tdata       (data_tdata),
    .i_tlast       (data_tlast),
    .i_tvalid      (data_tvalid),
    .i_tready      (data_tready)
  );

  initial begin
    rfnoc_chdr_clk = 1'b0;
    forever #10 rfnoc_chdr_clk = ~rfnoc_chdr_clk;
  end

  // Output port ready is random only while back-pressure is on
  always @(negedge rfnoc_chdr_clk) begin
    rdy_rnd = $random(seed);
    data_tready = bp_en ? rdy_rnd[1:0] : 2'b11;
  end

  // Watchdog whose limit grows with the traffic sent so far
  always @(posedge rfnoc_chdr_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > 40 * beats_sent + 2000) begin
      $display("Timeout after %0d cycles, the DUT stopped moving traffic or APB", cycle_cnt);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  // ----------------------------------------------------------------------
  // Reference model
  // ----------------------------------------------------------------------
  // Port of a kept packet, or ROUTE_OTHER or ROUTE_MISROUTED for a dropped one
  function automatic int ref_route(input logic [63:0] hdr, input logic [15:0] self_id);
    logic [2:0] ptype;
    logic [5:0] vc;
    ptype = hdr[55:53];
    vc    = hdr[63:58];
    if (ptype != TYPE_DATA && ptype != TYPE_DATA_TS && ptype != TYPE_STRC) begin
      return ROUTE_OTHER;
    end
    if (hdr[15:0] != self_id) begin
      return ROUTE_MISROUTED;
    end
    return (vc >= NUM_PORTS) ? 0 : int'(vc);
  endfunction

  function automatic int rand_len();
    logic [31:0] r;
    r = $random(seed);
    return 1 + int'(r % 6);
  endfunction

  // ----------------------------------------------------------------------
  // Stimulus tasks
  // ----------------------------------------------------------------------
  task automatic send_packet(input logic [2:0] ptype, input logic [5:0] vc,
                             input logic to_self, input int len);
    logic [63:0] beat;
    int          route;
    beat        = {$random(seed), $random(seed)};
    beat[63:58] = vc;
    beat[55:53] = ptype;
    beat[15:0]  = to_self ? epid : ~epid;
    route       = ref_route(beat, epid);
    if (route == ROUTE_OTHER) begin
      exp_other++;
    end else if (route == ROUTE_MISROUTED) begin
      exp_misrt++;
    end else begin
      exp_data++;
    end
    for (int i = 0; i < len; i++) begin
      if (i > 0) begin
        beat = {$random(seed), $random(seed)};
      end
      if (route >= 0) begin
        u_chk.expect_beat(route, i == len - 1, beat);
      end
      @(negedge rfnoc_chdr_clk);
      chdr_tdata  = beat;
      chdr_tlast  = (i == len - 1);
      chdr_tvalid = 1'b1;
      beats_sent++;
      do @(posedge rfnoc_chdr_clk); while (!chdr_tready);
    end
    @(negedge rfnoc_chdr_clk);
    chdr_tvalid = 1'b0;
    chdr_tlast  = 1'b0;
  endtask

  task automatic send_random_packet();
    logic [31:0] r;
    r = $random(seed);
    send_packet(r[2:0], {4'd0, r[4:3]}, r[6:5] != 2'b00, rand_len());
  endtask

  task automatic apb_access(input logic write, input logic [7:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
    @(negedge rfnoc_chdr_clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge rfnoc_chdr_clk);
    penable = 1'b1;
    do @(posedge rfnoc_chdr_clk); while (!pready);
    rdata = prdata;
    err   = pslverr;
    @(negedge rfnoc_chdr_clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic reg_write(input logic [7:0] addr, input logic [31:0] data);
    logic [31:0] rdata;
    logic        err;
    apb_access(1'b1, addr, data, rdata, err);
    u_chk.check_value("pslverr on register write", {31'd0, err}, 32'd0);
  endtask

  task automatic reg_read_check(input string name, input logic [7:0] addr,
                                input logic [31:0] expected);
    logic [31:0] rdata;
    logic        err;
    apb_access(1'b0, addr, 32'd0, rdata, err);
    u_chk.check_value({name, " pslverr"}, {31'd0, err}, 32'd0);
    u_chk.check_value(name, rdata, expected);
  endtask

  task automatic reg_expect_error(input string name, input logic write, input logic [7:0] addr);
    logic [31:0] rdata;
    logic        err;
    apb_access(write, addr, 32'hFFFF_FFFF, rdata, err);
    u_chk.check_value({name, " pslverr"}, {31'd0, err}, 32'd1);
  endtask

  task automatic check_counters();
    reg_read_check("data packet count", ADDR_DATA_CNT, exp_data);
    reg_read_check("other packet count", ADDR_OTHER_CNT, exp_other);
    reg_read_check("route error count", ADDR_ROUTE_ERR, exp_misrt);
  endtask

  task automatic drain();
    while (u_chk.pending_beats() != 0) begin
      @(posedge rfnoc_chdr_clk);
    end
    repeat (4) @(posedge rfnoc_chdr_clk);
  endtask

  task automatic end_test(input string name);
    if (u_chk.errors == errs_start) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d errors", name, u_chk.errors - errs_start);
    end
    errs_start = u_chk.errors;
  endtask

  // ----------------------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------------------
  initial begin
    rfnoc_chdr_rst = 1'b1;
    chdr_tdata     = '0;
    chdr_tlast     = 1'b0;
    chdr_tvalid    = 1'b0;
    data_tready    = 2'b11;
    psel           = 1'b0;
    penable        = 1'b0;
    pwrite         = 1'b0;
    paddr          = '0;
    pwdata         = '0;
    errs_start     = 0;
    repeat (16) @(negedge rfnoc_chdr_clk);
    rfnoc_chdr_rst = 1'b0;

    reg_read_check("endpoint ID after reset", ADDR_EPID, 32'd0);
    check_counters();
    reg_write(ADDR_EPID, 32'hABCD_1234);
    epid = 16'h1234;
    reg_read_check("endpoint ID", ADDR_EPID, 32'h0000_1234);
    end_test("Test 1 reset values and endpoint ID");

    // Every forwarded type on in-range and out-of-range VCs
    for (int t = 0; t < 3; t++) begin
      for (int v = 0; v < 4; v++) begin
        send_packet((t == 0) ? TYPE_DATA : ((t == 1) ? TYPE_DATA_TS : TYPE_STRC),
                    (v == 3) ? 6'd5 : 6'(v), 1'b1, rand_len());
      end
    end
    drain();
    end_test("Test 2 forwarding by VC");

    for (int n = 0; n < 30; n++) begin
      send_random_packet();
    end
    drain();
    check_counters();
    end_test("Test 3 dropping and packet counters");

    bp_en = 1'b1;
    for (int n = 0; n < 40; n++) begin
      send_random_packet();
    end
    drain();
    bp_en = 1'b0;
    check_counters();
    end_test("Test 4 random back-pressure");

    reg_write(ADDR_FLUSH, 32'd1);
    exp_data  = 0;
    exp_other = 0;
    exp_misrt = 0;
    check_counters();
    reg_expect_error("write to data packet count", 1'b1, ADDR_DATA_CNT);
    reg_expect_error("write to unmapped address", 1'b1, ADDR_UNMAPPED);
    reg_expect_error("read of unmapped address", 1'b0, ADDR_UNMAPPED);
    reg_expect_error("read of flush register", 1'b0, ADDR_FLUSH);
    end_test("Test 5 flush and slave errors");

    $display("Checks: %0d, beats compared: %0d, errors: %0d",
             u_chk.checks, u_chk.compared, u_chk.errors);
    if (u_chk.errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- chdr_ingress_endpoint.f
+incdir+hdl
hdl/chdr_ep_pkg.sv
hdl/chdr_pkt_classifier.sv
hdl/chdr_vc_router.sv
hdl/chdr_ep_regs.sv
hdl/chdr_ingress_endpoint.sv
tb/chdr_ep_checker.sv
tb/tb_chdr_ingress_endpoint.sv

//--- Bender.yml
package:
  name: chdr_ingress_endpoint

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/chdr_ep_pkg.sv
      - hdl/chdr_pkt_classifier.sv
      - hdl/chdr_vc_router.sv
      - hdl/chdr_ep_regs.sv
      - hdl/chdr_ingress_endpoint.sv
  - target: test
    files:
      - tb/chdr_ep_checker.sv
      - tb/tb_chdr_ingress_endpoint.sv
